// ==== common/call_pkg.sv ====
package call_pkg;

	////////////////////////////////////////////////////////////
	// call states
	////////////////////////////////////////////////////////////

	typedef enum logic [2:0] {
		idle       = 3'd0, // no call in progress
		incoming   = 3'd1, // being called
		outgoing   = 3'd2, // calling another node
		busy       = 3'd3, // call connected
		initialize = 3'd5  // waiting for enter at power up
	} call_state_t;

	////////////////////////////////////////////////////////////
	// commands to and from the application layer
	////////////////////////////////////////////////////////////

	// ui -> application
	typedef enum logic [2:0] {
		init_signal = 3'd0,
		make_call   = 3'd1, // address holds the dialled node
		stop_call   = 3'd2
	} ui_cmd_t;

	// application -> ui, sampled every cycle
	typedef enum logic [2:0] {
		none          = 3'd0,
		connected     = 3'd1,
		failed        = 3'd4, // dropped or never went through
		incoming_call = 3'd5,
		call_ended    = 3'd6
	} app_cmd_t;

	// one-cycle button strobes
	typedef struct packed {
		logic up;
		logic down;
		logic left;
		logic right;
		logic enter;
	} buttons_t;

endpackage

// ==== common/menu_pkg.sv ====
package menu_pkg;

	// numbered in list order, lists must stay contiguous
	typedef enum logic [5:0] {
		def_init, def_welcome, def_sys,
		call_number, voicemail, get_num, set_time,       // main list
		dialing,
		toggle_v, unread, saved,                         // voicemail list
		play_unread, del_unread, del_all_unread,         // unread list
		play_saved, del_saved, del_all_saved,            // saved list
		def_incoming, accept, reject,                    // incoming list
		def_outgoing, end_call,                          // outgoing list
		def_busy, end_call_b                             // busy list
	} menu_item_t;

	typedef struct packed {
		logic       valid; // item sits in a scrollable list
		menu_item_t first;
		menu_item_t last;
	} menu_list_t;

	typedef struct packed {
		logic [10:0] addr;   // start of string in text rom
		logic [10:0] length; // characters
	} text_req_t;

	typedef struct packed {
		logic      valid; // item has something to show
		text_req_t req;
	} text_entry_t;

	// list bounds for up/down wrapping
	function automatic menu_list_t list_of(menu_item_t item);
		menu_list_t l;
		case (item) inside
			[call_number:set_time]:         l = '{1'b1, call_number, set_time};
			[toggle_v:saved]:               l = '{1'b1, toggle_v, saved};
			[play_unread:del_all_unread]:   l = '{1'b1, play_unread, del_all_unread};
			[play_saved:del_all_saved]:     l = '{1'b1, play_saved, del_all_saved};
			[def_incoming:reject]:          l = '{1'b1, def_incoming, reject};
			[def_outgoing:end_call]:        l = '{1'b1, def_outgoing, end_call};
			[def_busy:end_call_b]:          l = '{1'b1, def_busy, end_call_b};
			default:                        l = '{1'b0, item, item}; // not in a list
		endcase
		return l;
	endfunction

	////////////////////////////////////////////////////////////
	// text rom map
	////////////////////////////////////////////////////////////

	function automatic text_entry_t text_entry(menu_item_t item, logic vm_on);
		text_entry_t e;
		e = '{1'b1, '{11'd0, 11'd0}};
		case (item)
			def_init:       e.req = '{11'd0, 11'd45};   // press enter to start
			def_welcome:    e.req = '{11'd72, 11'd7};
			call_number:    e.req = '{11'd80, 11'd11};
			voicemail:      e.req = '{11'd128, 11'd9};
			get_num:        e.req = '{11'd468, 11'd21};
			set_time:       e.req = '{11'd452, 11'd15};
			// wording offers the opposite of the current flag
			toggle_v:       e.req = vm_on ? text_req_t'{11'd138, 11'd18}
			                              : text_req_t'{11'd157, 11'd17};
			unread:         e.req = '{11'd175, 11'd16};
			saved:          e.req = '{11'd270, 11'd15};
			play_unread:    e.req = '{11'd191, 11'd25};
			del_unread:     e.req = '{11'd218, 11'd23};
			del_all_unread: e.req = '{11'd242, 11'd27};
			play_saved:     e.req = '{11'd286, 11'd24};
			del_saved:      e.req = '{11'd311, 11'd22};
			del_all_saved:  e.req = '{11'd334, 11'd26};
			def_incoming:   e.req = '{11'd361, 11'd13};
			accept:         e.req = '{11'd375, 11'd20};
			reject:         e.req = '{11'd396, 11'd20};
			def_outgoing:   e.req = '{11'd435, 11'd7};
			end_call,
			end_call_b:     e.req = '{11'd443, 11'd8};  // shared string
			def_busy:       e.req = '{11'd490, 11'd12};
			default:        e.valid = 1'b0;             // def_sys, dialing
		endcase
		return e;
	endfunction

endpackage

// ==== ui_control/ui_control.sv ====
`timescale 1ns/1ps

module ui_control import call_pkg::*, menu_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  buttons_t    buttons,
	input  app_cmd_t    inc_command,
	input  logic        voicemail_on,
	output call_state_t state,
	output menu_item_t  menu_item,
	output logic        dial_strobe,
	output logic        end_strobe,
	output logic        voicemail_toggle
);

	call_state_t state_nxt;
	menu_item_t  item_nxt;
	menu_list_t  lst;
	logic        nav;      // no call event, buttons may act
	logic        dial_nxt;
	logic        end_nxt;
	logic        flip_vm;
	logic        vm_want;  // requested voicemail flag

	assign lst = list_of(menu_item);

	// high until settings catch up, one cycle per select
	assign voicemail_toggle = vm_want ^ voicemail_on;

	////////////////////////////////////////////////////////////
	// call events, incoming command beats buttons
	////////////////////////////////////////////////////////////

	always_comb begin
		state_nxt = state;
		item_nxt  = menu_item;
		dial_nxt  = 1'b0;
		end_nxt   = 1'b0;
		flip_vm   = 1'b0;
		nav       = 1'b0;

		case (state)
			initialize: begin
				if (buttons.enter) begin // only enter wakes the node
					state_nxt = idle;
					item_nxt  = def_welcome;
				end
			end
			idle: begin
				if (inc_command == incoming_call) begin
					state_nxt = incoming;
					item_nxt  = def_incoming;
				end else
					nav = 1'b1;
			end
			outgoing: begin
				if (inc_command == connected) begin
					state_nxt = busy;
					item_nxt  = def_busy;
				end else if (inc_command == failed || inc_command == call_ended) begin
					state_nxt = idle;
					item_nxt  = def_sys;
				end else
					nav = 1'b1;
			end
			busy: begin
				if (inc_command == call_ended) begin // far end or our stop_call
					state_nxt = idle;
					item_nxt  = def_sys;
				end else
					nav = 1'b1;
			end
			incoming: nav = 1'b1;
			default: begin // unused encodings, start over
				state_nxt = initialize;
				item_nxt  = def_init;
			end
		endcase

		////////////////////////////////////////////////////////////
		// buttons: up, down, select, left
		////////////////////////////////////////////////////////////

		if (nav) begin
			if (buttons.up) begin
				if (lst.valid) // wrap to bottom
					item_nxt = (menu_item == lst.first) ? lst.last
					                                    : menu_item_t'(menu_item - 6'd1);
			end else if (buttons.down) begin
				if (lst.valid) // wrap to top
					item_nxt = (menu_item == lst.last) ? lst.first
					                                   : menu_item_t'(menu_item + 6'd1);
			end else if (buttons.right || buttons.enter) begin
				case (menu_item)
					def_welcome,
					def_sys:     item_nxt = call_number;
					call_number: item_nxt = dialing;
					voicemail:   item_nxt = toggle_v;
					unread:      item_nxt = play_unread;
					saved:       item_nxt = play_saved;
					dialing: begin
						dial_nxt  = 1'b1; // latch switches, send make_call
						state_nxt = outgoing;
						item_nxt  = def_outgoing;
					end
					toggle_v:    flip_vm = 1'b1;
					def_incoming,
					accept: begin
						state_nxt = busy;
						item_nxt  = def_busy;
					end
					reject: begin
						state_nxt = idle;
						item_nxt  = def_welcome;
					end
					end_call,
					end_call_b:  end_nxt = 1'b1; // wait for call_ended
					default:     item_nxt = menu_item; // get_num, set_time, playback items
				endcase
			end else if (buttons.left) begin
				case (menu_item) inside
					[call_number:set_time]:       item_nxt = def_sys;
					dialing:                      item_nxt = call_number;
					[toggle_v:saved]:             item_nxt = voicemail;
					[play_unread:del_all_unread]: item_nxt = unread;
					[play_saved:del_all_saved]:   item_nxt = saved;
					default:                      item_nxt = menu_item; // top level or call menus
				endcase
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= initialize;
			menu_item   <= def_init;
			dial_strobe <= 1'b0;
			end_strobe  <= 1'b0;
			vm_want     <= 1'b0; // settings clear to off as well
		end else begin
			state       <= state_nxt;
			menu_item   <= item_nxt;
			dial_strobe <= dial_nxt;
			end_strobe  <= end_nxt;
			if (flip_vm)
				vm_want <= ~vm_want;
		end
	end

endmodule

// ==== source/ui_settings.sv ====
`timescale 1ns/1ps

module ui_settings import call_pkg::*; #(
	parameter int dial_w = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  logic [dial_w-1:0] dial_switches,
	input  logic              dial_strobe,
	input  logic              end_strobe,
	input  logic              voicemail_toggle,
	output logic [dial_w-1:0] address,
	output ui_cmd_t           command,
	output logic              voicemail_on
);

	////////////////////////////////////////////////////////////
	// call request and voicemail flag
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			address      <= '0;
			command      <= init_signal;
			voicemail_on <= 1'b0; // voicemail off after power up
		end else begin
			if (dial_strobe) begin
				address <= dial_switches; // node to call
				command <= make_call;
			end else if (end_strobe)
				command <= stop_call; // address kept for the hang up

			if (voicemail_toggle)
				voicemail_on <= ~voicemail_on;
		end
	end

endmodule

// ==== source/text_lookup.sv ====
`timescale 1ns/1ps

module text_lookup import menu_pkg::*; (
	input  logic       clk,
	input  logic       reset,
	input  menu_item_t menu_item,
	input  logic       voicemail_on,
	output logic       text_start,
	output text_req_t  text
);

	menu_item_t  prev_item; // item seen last cycle
	text_entry_t entry;
	logic        changed;

	// lookup on the current item, flag read at request time
	assign entry   = text_entry(menu_item, voicemail_on);
	assign changed = (menu_item != prev_item);

	////////////////////////////////////////////////////////////
	// change detect and request
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			// differs from def_init, so the first screen goes out
			// right after reset releases
			prev_item  <= def_sys;
			text_start <= 1'b0;
		end else begin
			prev_item  <= menu_item;
			text_start <= changed && entry.valid; // one cycle per change
		end
	end

	// no text for the item, scroller keeps old string
	always_ff @(posedge clk) begin
		if (!reset && changed && entry.valid)
			text <= entry.req;
	end

endmodule

// ==== source/phone_ui_top.sv ====
`timescale 1ns/1ps

module phone_ui_top import call_pkg::*, menu_pkg::*; #(
	parameter int dial_w = 8
) (
	input  logic              clk,
	input  logic              reset,
	input  buttons_t          buttons,
	input  logic [dial_w-1:0] dial_switches,
	input  app_cmd_t          inc_command,
	output logic [dial_w-1:0] address,
	output ui_cmd_t           command,
	output call_state_t       current_state,
	output menu_item_t        current_menu_item,
	output logic              text_start,
	output text_req_t         text
);

	logic dial_strobe;      // select on dialing
	logic end_strobe;       // select on end call
	logic voicemail_toggle;
	logic voicemail_on;

	ui_control ctrl_i (
		.clk, .reset, .buttons, .inc_command, .voicemail_on,
		.state            (current_state),
		.menu_item        (current_menu_item),
		.dial_strobe, .end_strobe, .voicemail_toggle
	);

	ui_settings #(.dial_w(dial_w)) settings_i (
		.clk, .reset, .dial_switches,
		.dial_strobe, .end_strobe, .voicemail_toggle,
		.address, .command, .voicemail_on
	);

	text_lookup text_i (
		.clk, .reset,
		.menu_item        (current_menu_item),
		.voicemail_on, .text_start, .text
	);

endmodule

// ==== test/phone_ui_assert.sv ====
`timescale 1ns/1ps

module phone_ui_assert import call_pkg::*, menu_pkg::*; #(
	parameter int dial_w = 8
) (
	input logic              clk,
	input logic              reset,
	input logic [dial_w-1:0] address,
	input ui_cmd_t           command,
	input call_state_t       current_state,
	input menu_item_t        current_menu_item,
	input logic              text_start
);

	// one request per menu change, never stretched
	text_pulse_a: assert property (@(posedge clk) disable iff (reset)
		text_start |=> !text_start)
		else $error("text_start high for two cycles in a row");

	command_legal_a: assert property (@(posedge clk) disable iff (reset)
		command inside {init_signal, make_call, stop_call})
		else $error("command holds an illegal encoding");

	// reset values one edge later
	reset_values_a: assert property (@(posedge clk)
		reset |=> (current_state == initialize && current_menu_item == def_init
			&& command == init_signal && address == '0 && !text_start))
		else $error("outputs not at reset values after reset");

endmodule

bind phone_ui_top phone_ui_assert #(.dial_w(dial_w)) assert_i (
	.clk, .reset, .address, .command, .current_state, .current_menu_item, .text_start
);

// ==== test/tb_phone_ui.sv ====
`timescale 1ns/1ps

module tb_phone_ui import call_pkg::*, menu_pkg::*;;

	localparam int dial_w = 8;

	// one-hot button patterns in struct order up down left right enter
	localparam buttons_t btn_up    = 5'b10000;
	localparam buttons_t btn_down  = 5'b01000;
	localparam buttons_t btn_left  = 5'b00100;
	localparam buttons_t btn_right = 5'b00010;
	localparam buttons_t btn_enter = 5'b00001;

	logic              clk;
	logic              reset;
	buttons_t          buttons;
	logic [dial_w-1:0] dial_switches;
	app_cmd_t          inc_command;
	logic [dial_w-1:0] address;
	ui_cmd_t           command;
	call_state_t       current_state;
	menu_item_t        current_menu_item;
	logic              text_start;
	text_req_t         text;

	int     errors;
	int     checks;
	int     tests_run;
	integer seed;

	phone_ui_top #(.dial_w(dial_w)) dut_i (
		.clk, .reset, .buttons, .dial_switches, .inc_command,
		.address, .command, .current_state, .current_menu_item,
		.text_start, .text
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	////////////////////////////////////////////////////////////
	// stimulus helpers driven on the falling edge
	////////////////////////////////////////////////////////////

	// single-cycle strobe
	task automatic press_button(input buttons_t b);
		buttons = b;
		@(negedge clk);
		buttons = '0;
	endtask

	// app command held for one cycle only
	task automatic send_event(input app_cmd_t c);
		inc_command = c;
		@(negedge clk);
		inc_command = none;
	endtask

	////////////////////////////////////////////////////////////
	// checks
	////////////////////////////////////////////////////////////

	task automatic check_screen(input call_state_t st, input menu_item_t item);
		checks++;
		assert (current_state == st && current_menu_item == item) else begin
			$display("CHECK FAILED at %0d ns: state/item %s/%s, expected %s/%s", $time,
				current_state.name(), current_menu_item.name(), st.name(), item.name());
			errors++;
		end
	endtask

	task automatic check_command(input ui_cmd_t c);
		checks++;
		assert (command == c) else begin
			$display("CHECK FAILED at %0d ns: command %s, expected %s",
				$time, command.name(), c.name());
			errors++;
		end
	endtask

	task automatic check_address(input logic [dial_w-1:0] a);
		checks++;
		assert (address == a) else begin
			$display("CHECK FAILED at %0d ns: address %h, expected %h", $time, address, a);
			errors++;
		end
	endtask

	// text fields compared once the pulse shows up within 20 cycles
	task automatic wait_text(input logic [10:0] exp_addr, input logic [10:0] exp_len);
		int cycles;
		cycles = 0;
		while (!text_start && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		checks++;
		if (!text_start) begin
			$display("timeout at %0d ns: no text request within 20 cycles", $time);
			errors++;
		end else begin
			assert (text.addr == exp_addr && text.length == exp_len) else begin
				$display("CHECK FAILED at %0d ns: text %0d/%0d, expected %0d/%0d",
					$time, text.addr, text.length, exp_addr, exp_len);
				errors++;
			end
		end
	endtask

	task automatic no_text();
		repeat (3) begin
			@(negedge clk);
			checks++;
			assert (!text_start) else begin
				$display("CHECK FAILED at %0d ns: unexpected text_start", $time);
				errors++;
			end
		end
	endtask

	// wait loop for the settings register
	task automatic wait_command(input ui_cmd_t c);
		int cycles;
		cycles = 0;
		while (command != c && cycles < 20) begin
			@(negedge clk);
			cycles++;
		end
		check_command(c);
	endtask

	task automatic report_test(input string name, input int start_errs);
		tests_run++;
		$display("%-16s %s", name, (errors == start_errs) ? "ok" : "errors");
	endtask

	////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////

	task automatic test_startup();
		int start_errs;
		start_errs = errors;
		check_screen(initialize, def_init);
		wait_text(11'd0, 11'd45); // first screen after reset
		press_button(btn_enter);
		check_screen(idle, def_welcome);
		wait_text(11'd72, 11'd7);
		report_test("startup", start_errs);
	endtask

	task automatic test_main_menu();
		int start_errs;
		start_errs = errors;
		press_button(btn_right);
		check_screen(idle, call_number);
		wait_text(11'd80, 11'd11);
		press_button(btn_up); // wraps to bottom
		check_screen(idle, set_time);
		wait_text(11'd452, 11'd15);
		press_button(btn_down); // and back to top
		check_screen(idle, call_number);
		wait_text(11'd80, 11'd11);
		press_button(btn_left);
		check_screen(idle, def_sys);
		no_text();
		report_test("main_menu", start_errs);
	endtask

	task automatic test_voicemail();
		int start_errs;
		start_errs = errors;
		press_button(btn_right);
		wait_text(11'd80, 11'd11);
		press_button(btn_down);
		check_screen(idle, voicemail);
		wait_text(11'd128, 11'd9);
		press_button(btn_right);
		check_screen(idle, toggle_v);
		wait_text(11'd157, 11'd17); // voicemail off
		press_button(btn_right);    // flip flag on the same item
		check_screen(idle, toggle_v);
		no_text();
		press_button(btn_down);
		check_screen(idle, unread);
		wait_text(11'd175, 11'd16);
		press_button(btn_up);
		check_screen(idle, toggle_v);
		wait_text(11'd138, 11'd18); // now on
		press_button(btn_left);
		wait_text(11'd128, 11'd9);
		press_button(btn_left);
		check_screen(idle, def_sys);
		no_text();
		report_test("voicemail", start_errs);
	endtask

	task automatic test_dialled_call();
		int                start_errs;
		logic [dial_w-1:0] sw;
		start_errs    = errors;
		sw            = dial_w'($random(seed));
		dial_switches = sw;
		press_button(btn_right);
		wait_text(11'd80, 11'd11);
		press_button(btn_right);
		check_screen(idle, dialing);
		no_text(); // dialing shows nothing
		press_button(btn_right);
		check_screen(outgoing, def_outgoing);
		wait_text(11'd435, 11'd7);
		check_address(sw);
		check_command(make_call);
		send_event(connected);
		check_screen(busy, def_busy);
		wait_text(11'd490, 11'd12);
		press_button(btn_down);
		check_screen(busy, end_call_b);
		wait_text(11'd443, 11'd8);
		press_button(btn_right); // hang up
		wait_command(stop_call);
		send_event(call_ended);
		check_screen(idle, def_sys);
		no_text();
		report_test("dialled_call", start_errs);
	endtask

	task automatic test_failed_call();
		int start_errs;
		start_errs = errors;
		press_button(btn_right);
		wait_text(11'd80, 11'd11);
		press_button(btn_right);
		check_screen(idle, dialing);
		press_button(btn_right);
		check_screen(outgoing, def_outgoing);
		wait_text(11'd435, 11'd7);
		check_command(make_call);
		send_event(failed);
		check_screen(idle, def_sys);
		no_text();
		report_test("failed_call", start_errs);
	endtask

	task automatic test_incoming_call();
		int start_errs;
		start_errs = errors;
		send_event(incoming_call);
		check_screen(incoming, def_incoming);
		wait_text(11'd361, 11'd13);
		press_button(btn_down);
		check_screen(incoming, accept);
		wait_text(11'd375, 11'd20);
		press_button(btn_down);
		check_screen(incoming, reject);
		wait_text(11'd396, 11'd20);
		press_button(btn_right); // reject
		check_screen(idle, def_welcome);
		wait_text(11'd72, 11'd7);
		send_event(incoming_call); // second call gets accepted
		wait_text(11'd361, 11'd13);
		press_button(btn_down);
		wait_text(11'd375, 11'd20);
		press_button(btn_right);
		check_screen(busy, def_busy);
		wait_text(11'd490, 11'd12);
		send_event(call_ended);
		check_screen(idle, def_sys);
		report_test("incoming_call", start_errs);
	endtask

	////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////

	initial begin
		errors        = 0;
		checks        = 0;
		tests_run     = 0;
		seed          = 32'h557d1aca;
		reset         = 1'b1;
		buttons       = '0;
		dial_switches = '0;
		inc_command   = none;
		repeat (3) @(negedge clk); // three reset edges
		reset = 1'b0;

		test_startup();
		test_main_menu();
		test_voicemail();
		test_dialled_call();
		test_failed_call();
		test_incoming_call();

		$display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

// ==== sources.f ====
common/call_pkg.sv
common/menu_pkg.sv
ui_control/ui_control.sv
source/ui_settings.sv
source/text_lookup.sv
source/phone_ui_top.sv
test/phone_ui_assert.sv
test/tb_phone_ui.sv

// ==== Makefile ====
SRCS = $(shell cat sources.f)

obj_dir/Vtb_phone_ui: sources.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_phone_ui -f sources.f -o Vtb_phone_ui

run: obj_dir/Vtb_phone_ui
	./obj_dir/Vtb_phone_ui > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Result: FAILED" sim.log
	grep -q "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
